// ==== common/fdiv_ctl_pkg.sv ====
`default_nettype none

package fdiv_ctl_pkg;

	// round to nearest even works on three guard bits.
	localparam int GUARD_W = 3;
	localparam int QUO_W = fdiv_fmt_pkg::MANT_W + 1 + GUARD_W;

	// one extra exponent bit catches wrap below zero.
	localparam int XEXP_W = fdiv_fmt_pkg::EXP_W + 1;
	localparam int UNDER_LIM = (2 ** fdiv_fmt_pkg::EXP_W - 1) + fdiv_fmt_pkg::BIAS - 1;
	localparam int OVER_LIM = 2 ** fdiv_fmt_pkg::EXP_W - 2;

	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_LAUNCH,
		UNIT_WAIT
	} unit_state_e;

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_DIV,
		CORE_NORM,
		CORE_ROUND
	} core_state_e;

endpackage

`default_nettype wire

// ==== common/fdiv_fmt_pkg.sv ====
`default_nettype none

package fdiv_fmt_pkg;

	// ieee single precision layout.
	localparam int EXP_W = 8;
	localparam int MANT_W = 23;
	localparam int WORD_W = 1 + EXP_W + MANT_W;

	// exponent bias of the stored field.
	localparam int BIAS = 127;

	// all-ones exponent marks infinity and NaN.
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	// quiet NaN carries only the top mantissa bit.
	localparam logic [MANT_W-1:0] QNAN_MANT = {1'b1, {(MANT_W-1){1'b0}}};

	// operand classes.
	typedef enum logic [2:0] {
		CLS_ZERO,
		CLS_SUB,
		CLS_NORM,
		CLS_INF,
		CLS_NAN
	} fp_class_e;

endpackage

`default_nettype wire

// ==== rtl/fdiv_core/fdiv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_core (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            stb_i,
	input  logic [fdiv_fmt_pkg::MANT_W:0]   a_mant_i,
	input  logic [fdiv_fmt_pkg::MANT_W:0]   b_mant_i,
	input  logic [fdiv_fmt_pkg::EXP_W-1:0]  a_exp_i,
	input  logic [fdiv_fmt_pkg::EXP_W-1:0]  b_exp_i,
	output logic [fdiv_ctl_pkg::XEXP_W-1:0] exp_o,
	output logic [fdiv_fmt_pkg::MANT_W:0]   mant_o,
	output logic                            rdy_o
);

	localparam int G = fdiv_ctl_pkg::GUARD_W;
	localparam int XW = fdiv_ctl_pkg::XEXP_W;

	fdiv_ctl_pkg::core_state_e state;
	logic div_stb;
	logic div_rdy;
	logic [fdiv_ctl_pkg::QUO_W-1:0] quo;
	logic [XW-1:0] exp_diff;

	assign div_stb = stb_i && (state == fdiv_ctl_pkg::CORE_IDLE);
	assign rdy_o = (state == fdiv_ctl_pkg::CORE_IDLE);

	// biased difference, wraps below zero into the extra bit.
	always_ff @(posedge clk_i) begin
		if (div_stb) begin
			exp_diff <= {1'b0, a_exp_i} + XW'(fdiv_fmt_pkg::BIAS) - {1'b0, b_exp_i};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= fdiv_ctl_pkg::CORE_IDLE;
		end else begin
			case (state)
				fdiv_ctl_pkg::CORE_IDLE: if (stb_i) state <= fdiv_ctl_pkg::CORE_DIV;
				fdiv_ctl_pkg::CORE_DIV: if (div_rdy) state <= fdiv_ctl_pkg::CORE_NORM;
				fdiv_ctl_pkg::CORE_NORM: state <= fdiv_ctl_pkg::CORE_ROUND;
				default: state <= fdiv_ctl_pkg::CORE_IDLE;
			endcase
		end
	end

	fdiv_mant_div u_div (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.stb_i (div_stb),
		.num_i ({a_mant_i, {G{1'b0}}}),
		.den_i ({b_mant_i, {G{1'b0}}}),
		.quo_o (quo),
		.rdy_o (div_rdy)
	);

	fdiv_norm_round u_norm_round (
		.clk_i  (clk_i),
		.exp_i  (exp_diff),
		.quo_i  (quo),
		.exp_o  (exp_o),
		.mant_o (mant_o)
	);

endmodule

`default_nettype wire

// ==== rtl/fdiv_core/fdiv_mant_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_mant_div (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           stb_i,
	input  logic [fdiv_ctl_pkg::QUO_W-1:0] num_i,
	input  logic [fdiv_ctl_pkg::QUO_W-1:0] den_i,
	output logic [fdiv_ctl_pkg::QUO_W-1:0] quo_o,
	output logic                           rdy_o
);

	localparam int W = fdiv_ctl_pkg::QUO_W;
	localparam int STEPS = 2 * W - 1;
	localparam int CNT_W = $clog2(STEPS + 1);

	logic [2*W-1:0] work;
	logic [2*W-1:0] diff;
	logic [CNT_W-1:0] step;

	// remainder minus the left-aligned divisor.
	assign diff = work - {1'b0, den_i, {(W-1){1'b0}}};

	// quotient bits collect at the bottom of the working register.
	assign quo_o = work[W-1:0];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy_o <= 1'b1;
			step <= '0;
		end else if (rdy_o) begin
			if (stb_i) begin
				rdy_o <= 1'b0;
				step <= '0;
			end
		end else begin
			// last step runs in this cycle too.
			if (step == CNT_W'(STEPS - 1)) begin
				rdy_o <= 1'b1;
			end
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rdy_o) begin
			if (stb_i) begin
				work <= {{W{1'b0}}, num_i};
			end
		end else if (diff[2*W-1]) begin
			// negative difference, keep the remainder.
			work <= {work[2*W-2:0], 1'b0};
		end else begin
			work <= {diff[2*W-2:0], 1'b1};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fdiv_core/fdiv_norm_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_norm_round (
	input  logic                            clk_i,
	input  logic [fdiv_ctl_pkg::XEXP_W-1:0] exp_i,
	input  logic [fdiv_ctl_pkg::QUO_W-1:0]  quo_i,
	output logic [fdiv_ctl_pkg::XEXP_W-1:0] exp_o,
	output logic [fdiv_fmt_pkg::MANT_W:0]   mant_o
);

	localparam int QW = fdiv_ctl_pkg::QUO_W;
	localparam int XW = fdiv_ctl_pkg::XEXP_W;
	localparam int MW = fdiv_fmt_pkg::MANT_W;
	localparam int G = fdiv_ctl_pkg::GUARD_W;
	localparam int MAX_SHIFT = 20;

	logic [4:0] lead_zeros;
	logic lead_found;
	logic [XW-1:0] norm_exp;
	logic [QW-1:0] norm_quo;
	logic [MW:0] kept;
	logic [MW+1:0] bumped;
	logic round_up;

	// leading one search over the top MAX_SHIFT+1 bits.
	always_comb begin
		lead_zeros = '0;
		lead_found = 1'b0;
		for (int i = 0; i <= MAX_SHIFT; i++) begin
			if (!lead_found && quo_i[QW-1-i]) begin
				lead_zeros = 5'(i);
				lead_found = 1'b1;
			end
		end
	end

	// a zero exponent or a far leading one leaves the quotient as is.
	always_ff @(posedge clk_i) begin
		if (exp_i != '0 && lead_found && lead_zeros != '0) begin
			norm_exp <= exp_i - XW'(lead_zeros);
			norm_quo <= quo_i << lead_zeros;
		end else begin
			norm_exp <= exp_i;
			norm_quo <= quo_i;
		end
	end

	assign kept = norm_quo[QW-1:G];
	assign bumped = {1'b0, kept} + 1'b1;

	// halfway goes up only when the kept lsb is odd.
	assign round_up = norm_quo[G-1] && (kept[0] || (|norm_quo[G-2:0]));

	always_ff @(posedge clk_i) begin
		if (!round_up) begin
			exp_o <= norm_exp;
			mant_o <= kept;
		end else if (bumped[MW+1]) begin
			// carry out of the mantissa.
			exp_o <= norm_exp + 1'b1;
			mant_o <= bumped[MW+1:1];
		end else begin
			exp_o <= norm_exp;
			mant_o <= bumped[MW:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fdiv_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_pool #(
	parameter int INSTCNT = 2,
	parameter int TAG_W = 5
) (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            stb_i,
	input  logic [fdiv_fmt_pkg::WORD_W-1:0] a_i,
	input  logic [fdiv_fmt_pkg::WORD_W-1:0] b_i,
	input  logic [TAG_W-1:0]                tag_i,
	output logic                            rdy_o,
	input  logic                            ostb_i,
	output logic [fdiv_fmt_pkg::WORD_W-1:0] data_o,
	output logic [TAG_W-1:0]                tag_o,
	output logic                            ordy_o
);

	localparam int IDX_W = (INSTCNT > 1) ? $clog2(INSTCNT) : 1;
	localparam logic [IDX_W:0] CNT = (IDX_W + 1)'(INSTCNT);

	// the top bit flips each time the index wraps past the last unit.
	function automatic logic [IDX_W:0] next_ptr(input logic [IDX_W:0] ptr);
		if (ptr[IDX_W-1:0] == IDX_W'(INSTCNT - 1)) begin
			return {~ptr[IDX_W], {IDX_W{1'b0}}};
		end
		return ptr + 1'b1;
	endfunction

	logic [IDX_W:0] wr_ptr;
	logic [IDX_W:0] rd_ptr;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W:0] usage;
	logic [INSTCNT-1:0] unit_rdy;
	logic [fdiv_fmt_pkg::WORD_W-1:0] unit_data [INSTCNT];
	logic [TAG_W-1:0] unit_tag [INSTCNT];

	assign wr_idx = wr_ptr[IDX_W-1:0];
	assign rd_idx = rd_ptr[IDX_W-1:0];
	assign usage = {1'b0, wr_idx} - {1'b0, rd_idx} +
		((wr_ptr[IDX_W] != rd_ptr[IDX_W]) ? CNT : '0);

	assign rdy_o = (usage < CNT) && unit_rdy[wr_idx];
	assign ordy_o = (usage != '0) && unit_rdy[rd_idx];
	assign data_o = unit_data[rd_idx];
	assign tag_o = unit_tag[rd_idx];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
		end else if (stb_i && rdy_o) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_ptr <= '0;
		end else if (ostb_i && ordy_o) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
	end

	for (genvar g = 0; g < INSTCNT; g++) begin : g_unit
		fdiv_unit #(
			.TAG_W (TAG_W)
		) u_unit (
			.clk_i  (clk_i),
			.rst_i  (rst_i),
			.stb_i  (stb_i && rdy_o && (wr_idx == IDX_W'(g))),
			.a_i    (a_i),
			.b_i    (b_i),
			.tag_i  (tag_i),
			.data_o (unit_data[g]),
			.tag_o  (unit_tag[g]),
			.rdy_o  (unit_rdy[g])
		);
	end

endmodule

`default_nettype wire

// ==== rtl/fdiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_unit #(
	parameter int TAG_W = 5
) (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            stb_i,
	input  logic [fdiv_fmt_pkg::WORD_W-1:0] a_i,
	input  logic [fdiv_fmt_pkg::WORD_W-1:0] b_i,
	input  logic [TAG_W-1:0]                tag_i,
	output logic [fdiv_fmt_pkg::WORD_W-1:0] data_o,
	output logic [TAG_W-1:0]                tag_o,
	output logic                            rdy_o
);

	localparam int EW = fdiv_fmt_pkg::EXP_W;
	localparam int MW = fdiv_fmt_pkg::MANT_W;
	localparam logic [EW-1:0] EXP_MAX = fdiv_fmt_pkg::EXP_MAX;

	function automatic fdiv_fmt_pkg::fp_class_e classify(input logic [fdiv_fmt_pkg::WORD_W-1:0] w);
		logic [EW-1:0] e;
		logic [MW-1:0] m;
		e = w[MW +: EW];
		m = w[MW-1:0];
		if (e == EXP_MAX) begin
			if (m != '0) return fdiv_fmt_pkg::CLS_NAN;
			return fdiv_fmt_pkg::CLS_INF;
		end
		if (e == '0) begin
			if (m != '0) return fdiv_fmt_pkg::CLS_SUB;
			return fdiv_fmt_pkg::CLS_ZERO;
		end
		return fdiv_fmt_pkg::CLS_NORM;
	endfunction

	fdiv_fmt_pkg::fp_class_e a_cls;
	fdiv_fmt_pkg::fp_class_e b_cls;
	fdiv_ctl_pkg::unit_state_e state;
	logic a_sign;
	logic b_sign;
	logic is_nan;
	logic is_inf;
	logic is_zero;
	logic core_stb;
	logic core_rdy;
	logic res_sign;
	logic [MW:0] a_mant;
	logic [MW:0] b_mant;
	logic [EW-1:0] a_exp;
	logic [EW-1:0] b_exp;
	logic [fdiv_ctl_pkg::XEXP_W-1:0] core_exp;
	logic [MW:0] core_mant;

	assign a_cls = classify(a_i);
	assign b_cls = classify(b_i);
	assign a_sign = a_i[fdiv_fmt_pkg::WORD_W-1];
	assign b_sign = b_i[fdiv_fmt_pkg::WORD_W-1];

	// rules are checked in priority order, NaN first.
	assign is_nan = (a_cls == fdiv_fmt_pkg::CLS_NAN) || (b_cls == fdiv_fmt_pkg::CLS_NAN) ||
		((a_cls == fdiv_fmt_pkg::CLS_ZERO || a_cls == fdiv_fmt_pkg::CLS_INF) &&
		b_cls == fdiv_fmt_pkg::CLS_ZERO) ||
		(a_cls == fdiv_fmt_pkg::CLS_INF && b_cls == fdiv_fmt_pkg::CLS_INF);
	assign is_inf = (a_cls == fdiv_fmt_pkg::CLS_INF) || (b_cls == fdiv_fmt_pkg::CLS_ZERO);
	assign is_zero = (a_cls == fdiv_fmt_pkg::CLS_ZERO) || (b_cls == fdiv_fmt_pkg::CLS_INF);

	assign core_stb = (state == fdiv_ctl_pkg::UNIT_LAUNCH);
	assign rdy_o = (state == fdiv_ctl_pkg::UNIT_IDLE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= fdiv_ctl_pkg::UNIT_IDLE;
		end else begin
			case (state)
				fdiv_ctl_pkg::UNIT_IDLE:
					if (stb_i && !(is_nan || is_inf || is_zero))
						state <= fdiv_ctl_pkg::UNIT_LAUNCH;
				fdiv_ctl_pkg::UNIT_LAUNCH: state <= fdiv_ctl_pkg::UNIT_WAIT;
				fdiv_ctl_pkg::UNIT_WAIT: if (core_rdy) state <= fdiv_ctl_pkg::UNIT_IDLE;
				default: state <= fdiv_ctl_pkg::UNIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == fdiv_ctl_pkg::UNIT_IDLE && stb_i) begin
			tag_o <= tag_i;
			res_sign <= a_sign ^ b_sign;
			// subnormals take exponent 1 with no hidden bit.
			a_exp <= (a_cls == fdiv_fmt_pkg::CLS_SUB) ? EW'(1) : a_i[MW +: EW];
			b_exp <= (b_cls == fdiv_fmt_pkg::CLS_SUB) ? EW'(1) : b_i[MW +: EW];
			a_mant <= {a_cls == fdiv_fmt_pkg::CLS_NORM, a_i[MW-1:0]};
			b_mant <= {b_cls == fdiv_fmt_pkg::CLS_NORM, b_i[MW-1:0]};
			if (is_nan) begin
				data_o <= {a_sign ^ b_sign, EXP_MAX, fdiv_fmt_pkg::QNAN_MANT};
			end else if (is_inf) begin
				data_o <= {a_sign, EXP_MAX, {MW{1'b0}}};
			end else if (is_zero) begin
				data_o <= {a_sign ^ b_sign, {(EW + MW){1'b0}}};
			end
		end else if (state == fdiv_ctl_pkg::UNIT_WAIT && core_rdy) begin
			// wrapped exponents land above the overflow limit.
			if (core_exp >= fdiv_ctl_pkg::UNDER_LIM) begin
				data_o <= {res_sign, {(EW + MW){1'b0}}};
			end else if (core_exp >= fdiv_ctl_pkg::OVER_LIM) begin
				data_o <= {res_sign, EXP_MAX, {MW{1'b0}}};
			end else begin
				data_o <= {res_sign, core_exp[EW-1:0], core_mant[MW-1:0]};
			end
		end
	end

	fdiv_core u_core (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.stb_i    (core_stb),
		.a_mant_i (a_mant),
		.b_mant_i (b_mant),
		.a_exp_i  (a_exp),
		.b_exp_i  (b_exp),
		.exp_o    (core_exp),
		.mant_o   (core_mant),
		.rdy_o    (core_rdy)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the divider pool testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fdiv_tb -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vfdiv_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0

// ==== sim/fdiv_pool_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_pool_sva #(
	parameter int INSTCNT = 2,
	parameter int IDX_W = 1
) (
	input wire logic         clk_i,
	input wire logic         rst_i,
	input wire logic         stb_i,
	input wire logic         rdy_i,
	input wire logic         ostb_i,
	input wire logic         ordy_i,
	input wire logic [31:0]  data_i,
	input wire logic [IDX_W:0] usage_i
);

	// occupancy moves by one per accepted request and per read result.
	a_usage_step: assert property (@(posedge clk_i) disable iff (rst_i)
		usage_i == $past(usage_i) + (IDX_W + 1)'($past(stb_i && rdy_i))
			- (IDX_W + 1)'($past(ostb_i && ordy_i)))
		else $error("occupancy out of step with the handshakes");

	a_usage_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		usage_i <= (IDX_W + 1)'(INSTCNT))
		else $error("more requests held than units");

	// an unread result stays put.
	a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		ordy_i && !ostb_i |=> ordy_i && $stable(data_i))
		else $error("held result changed before it was read");

	a_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> rdy_i && !ordy_i)
		else $error("handshake outputs wrong after reset");

endmodule

`default_nettype wire

// ==== sim/fdiv_model.svh ====
`ifndef FDIV_MODEL_SVH
`define FDIV_MODEL_SVH

// class of an operand from its exponent and mantissa fields.
function automatic fdiv_fmt_pkg::fp_class_e operand_class(input logic [31:0] w);
	if (w[30:23] == 8'hff) begin
		if (w[22:0] != 23'd0) return fdiv_fmt_pkg::CLS_NAN;
		return fdiv_fmt_pkg::CLS_INF;
	end
	if (w[30:23] == 8'h00) begin
		if (w[22:0] != 23'd0) return fdiv_fmt_pkg::CLS_SUB;
		return fdiv_fmt_pkg::CLS_ZERO;
	end
	return fdiv_fmt_pkg::CLS_NORM;
endfunction

// result word of a over b, bit for bit.
function automatic logic [31:0] expected_word(input logic [31:0] a, input logic [31:0] b);
	fdiv_fmt_pkg::fp_class_e ca;
	fdiv_fmt_pkg::fp_class_e cb;
	logic sign;
	logic [23:0] ma;
	logic [23:0] mb;
	logic [8:0] ea;
	logic [8:0] eb;
	logic [8:0] ex;
	logic [63:0] wide;
	logic [26:0] quo;
	logic [24:0] sum;
	logic [23:0] kept;
	int lead;
	ca = operand_class(a);
	cb = operand_class(b);
	sign = a[31] ^ b[31];
	if (ca == fdiv_fmt_pkg::CLS_NAN || cb == fdiv_fmt_pkg::CLS_NAN ||
		((ca == fdiv_fmt_pkg::CLS_ZERO || ca == fdiv_fmt_pkg::CLS_INF) &&
		cb == fdiv_fmt_pkg::CLS_ZERO) ||
		(ca == fdiv_fmt_pkg::CLS_INF && cb == fdiv_fmt_pkg::CLS_INF)) begin
		return {sign, 8'hff, 1'b1, 22'd0};
	end
	if (ca == fdiv_fmt_pkg::CLS_INF || cb == fdiv_fmt_pkg::CLS_ZERO) return {a[31], 8'hff, 23'd0};
	if (ca == fdiv_fmt_pkg::CLS_ZERO || cb == fdiv_fmt_pkg::CLS_INF) return {sign, 31'd0};
	// subnormals count as exponent 1 without the hidden bit.
	ma = {ca == fdiv_fmt_pkg::CLS_NORM, a[22:0]};
	mb = {cb == fdiv_fmt_pkg::CLS_NORM, b[22:0]};
	ea = (ca == fdiv_fmt_pkg::CLS_SUB) ? 9'd1 : {1'b0, a[30:23]};
	eb = (cb == fdiv_fmt_pkg::CLS_SUB) ? 9'd1 : {1'b0, b[30:23]};
	ex = ea + 9'd127 - eb;
	wide = ({40'd0, ma} << 26) / {40'd0, mb};
	quo = wide[26:0];
	// leading one within the top 21 bits.
	lead = -1;
	for (int i = 20; i >= 0; i--) begin
		if (quo[26-i]) lead = i;
	end
	if (ex != 9'd0 && lead > 0) begin
		quo = quo << lead;
		ex = ex - 9'(lead);
	end
	kept = quo[26:3];
	if (quo[2] && (kept[0] || quo[1] || quo[0])) begin
		sum = {1'b0, kept} + 25'd1;
		kept = sum[24] ? sum[24:1] : sum[23:0];
		ex = ex + {8'd0, sum[24]};
	end
	if (ex >= 9'd381) return {sign, 31'd0};
	if (ex >= 9'd254) return {sign, 8'hff, 23'd0};
	return {sign, ex[7:0], kept[22:0]};
endfunction

`endif

// ==== sim/fdiv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdiv_tb;

	localparam int INSTCNT = 3;
	localparam int TAG_W = 5;
	localparam int CLK_PERIOD = 40;
	localparam int REQ_CNT = 500;
	// at most 80 clock cycles per request.
	localparam int TIMEOUT = REQ_CNT * 80 * CLK_PERIOD;

	// class codes in the order of fdiv_fmt_pkg::fp_class_e.
	localparam int SPEC_A [8] = '{4, 0, 3, 3, 2, 0, 2, 2};
	localparam int SPEC_B [8] = '{2, 0, 3, 0, 0, 2, 3, 4};

	logic clk;
	logic rst;
	logic stb;
	logic [31:0] a;
	logic [31:0] b;
	logic [TAG_W-1:0] tag;
	logic rdy;
	logic ostb;
	logic [31:0] data;
	logic [TAG_W-1:0] otag;
	logic ordy;
	logic [31:0] next_a;
	logic [31:0] next_b;
	integer seed;
	int sent;
	int recv;
	logic [31:0] want_q [$];
	logic [TAG_W-1:0] tag_q [$];

	`include "fdiv_model.svh"

	fdiv_pool #(
		.INSTCNT (INSTCNT),
		.TAG_W   (TAG_W)
	) DUT (
		.clk_i  (clk),
		.rst_i  (rst),
		.stb_i  (stb),
		.a_i    (a),
		.b_i    (b),
		.tag_i  (tag),
		.rdy_o  (rdy),
		.ostb_i (ostb),
		.data_o (data),
		.tag_o  (otag),
		.ordy_o (ordy)
	);

	bind fdiv_pool fdiv_pool_sva #(
		.INSTCNT (INSTCNT),
		.IDX_W   (IDX_W)
	) u_sva (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.stb_i   (stb_i),
		.rdy_i   (rdy_o),
		.ostb_i  (ostb_i),
		.ordy_i  (ordy_o),
		.data_i  (data_o),
		.usage_i (usage)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// random word of a class; normals take an exponent from lo up.
	function automatic logic [31:0] class_word(input int cls, input int lo, input int span);
		int r;
		int e;
		r = $random(seed);
		e = lo + (($random(seed) & 32'h7fff) % span);
		case (cls)
			0: return {r[31], 31'd0};
			1: return {r[31], 8'd0, r[22:0] | 23'd1};
			3: return {r[31], 8'hff, 23'd0};
			4: return {r[31], 8'hff, r[22:0] | 23'd1};
			default: return {r[31], e[7:0], r[22:0]};
		endcase
	endfunction

	task automatic pick_operands(output logic [31:0] x, output logic [31:0] y);
		int cat;
		int k;
		cat = $random(seed) & 15;
		k = $random(seed) & 7;
		if (cat < 6) begin
			x = class_word(2, 64, 128);
			y = class_word(2, 64, 128);
		end else if (cat < 9) begin
			// full exponent range reaches overflow and underflow.
			x = class_word(2, 1, 254);
			y = class_word(2, 1, 254);
		end else if (cat < 12) begin
			x = class_word(SPEC_A[k], 1, 254);
			y = class_word(SPEC_B[k], 1, 254);
		end else if (cat < 14) begin
			x = class_word(1, 1, 1);
			y = class_word(2, 1, 254);
		end else begin
			// dividend mantissa stays below twice the divisor's.
			x = class_word(1, 1, 1);
			y = class_word(1, 1, 1);
			if (y[22:0] <= (x[22:0] >> 1)) y[22:0] = (x[22:0] >> 1) + 23'd1;
		end
	endtask

	initial begin
		#(TIMEOUT);
		$display("timeout, the results did not all come out in time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 32'haf7b;
		sent = 0;
		recv = 0;
		clk = 1'b0;
		rst = 1'b1;
		stb = 1'b0;
		a = '0;
		b = '0;
		tag = '0;
		ostb = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_value({31'd0, rdy}, 32'd1, "rdy_o after reset");
		check_value({31'd0, ordy}, 32'd0, "ordy_o after reset");
		while (recv < REQ_CNT) begin
			if (stb && rdy) begin
				want_q.push_back(expected_word(a, b));
				tag_q.push_back(tag);
				sent++;
			end
			if (ostb && ordy) begin
				if (want_q.size() == 0) begin
					$display("a result came out with no request outstanding");
					$display("TEST FAILED");
					$fatal(1, "unexpected result");
				end else begin
					check_value(data, want_q.pop_front(), "data_o");
					check_value({27'd0, otag}, {27'd0, tag_q.pop_front()}, "tag_o");
					recv++;
				end
			end
			// a refused request keeps its operands.
			if (sent < REQ_CNT && (!stb || rdy)) begin
				pick_operands(next_a, next_b);
				a <= next_a;
				b <= next_b;
				tag <= TAG_W'(sent);
			end
			stb <= (sent < REQ_CNT) && (($random(seed) & 3) != 0);
			ostb <= ($random(seed) & 7) > 2;
			@(posedge clk);
		end
		if (want_q.size() != 0 || sent != REQ_CNT) begin
			$display("requests were left over after the last result");
			$display("TEST FAILED");
			$fatal(1, "leftover requests");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
common/fdiv_fmt_pkg.sv
common/fdiv_ctl_pkg.sv
rtl/fdiv_core/fdiv_mant_div.sv
rtl/fdiv_core/fdiv_norm_round.sv
rtl/fdiv_core/fdiv_core.sv
rtl/fdiv_unit.sv
rtl/fdiv_pool.sv
sim/fdiv_pool_sva.sv
sim/fdiv_tb.sv
